// File: Bender.yml
package:
  name: mem_stage

sources:
  # package first, then the units and the top level.
  - files:
      - src/mem_stage_pkg.sv
      - src/single_xfer.sv
      - src/block_xfer.sv
      - src/xfer_merge.sv
      - src/mem_stage.sv

  # testbench with the bound assertions.
  - target: test
    files:
      - tb/mem_stage_props.sv
      - tb/tb_mem_stage.sv

dependencies: {}

export_include_dirs: []

__________

// File: mem_stage.f
src/mem_stage_pkg.sv
src/single_xfer.sv
src/block_xfer.sv
src/xfer_merge.sv
src/mem_stage.sv
tb/mem_stage_props.sv
tb/tb_mem_stage.sv

// File: src/block_xfer.sv
`timescale 1ns/10ps

module block_xfer import mem_stage_pkg::*; #(
	parameter int addr_w = 32
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              bubble,
	input  word_t             insn,
	input  word_t             op0,
	input  word_t             rd_data,
	input  word_t             st_data,
	input  logic              bus_wait,
	output logic              b_rd_req,
	output logic              b_wr_req,
	output logic [addr_w-1:0] b_addr,
	output word_t             b_wr_data,
	output logic              b_busy,
	output logic              b_wb_req,
	output reg_num_t          b_wb_num,
	output word_t             b_wb_data,
	output reg_num_t          st_read
);

	block_state_t state;
	reg_list_t list_q;
	word_t addr_q;
	logic [4:0] cnt_q;

	logic active;
	logic ld;
	logic wbf;
	logic base_phase;
	reg_list_t cur_list;
	reg_list_t next_list;
	word_t cur_addr;
	logic [4:0] cur_cnt;
	reg_num_t cur_num;
	logic has_word;
	logic done_word;
	logic last_word;

	assign active = is_block_xfer(insn) && !bubble;
	assign ld = insn[load_bit];
	assign wbf = insn[wb_bit];
	assign base_phase = active && (state == blk_base_wb);

	// first word comes straight from the insn.
	assign cur_list = (state == blk_xfer) ? list_q : insn[15:0];
	assign cur_addr = (state == blk_xfer) ? addr_q : op0;
	assign cur_cnt = (state == blk_xfer) ? cnt_q : 5'd0;

	// clear the lowest set bit.
	assign next_list = cur_list & (cur_list - 16'd1);

	always_comb begin
		cur_num = '0;
		for (int i = 15; i >= 0; i--) begin
			if (cur_list[i]) begin
				cur_num = reg_num_t'(i);
			end
		end
	end

	assign has_word = active && (state != blk_base_wb) && (cur_list != '0);
	assign done_word = has_word && !bus_wait;
	assign last_word = done_word && (next_list == '0);

	assign b_rd_req = has_word && ld;
	assign b_wr_req = has_word && !ld;
	assign b_addr = has_word ? cur_addr[addr_w-1:0] : '0;
	assign st_read = cur_num;
	assign b_wr_data = b_wr_req ? st_data : '0;

	// final cycle is the last word, or the base writeback.
	assign b_busy = has_word && !(last_word && !wbf);

	always_comb begin
		b_wb_req = 1'b0;
		b_wb_num = '0;
		b_wb_data = '0;
		if (base_phase) begin
			b_wb_req = 1'b1;
			b_wb_num = insn[base_msb:base_lsb];
			b_wb_data = op0 + {25'd0, cnt_q, 2'b00};
		end else if (done_word && ld) begin
			b_wb_req = 1'b1;
			b_wb_num = cur_num;
			b_wb_data = rd_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= blk_idle;
		end else if (done_word) begin
			if (!last_word) begin
				state <= blk_xfer;
			end else if (wbf) begin
				state <= blk_base_wb;
			end else begin
				state <= blk_idle;
			end
		end else if (state == blk_base_wb) begin
			state <= blk_idle;
		end
	end

	always_ff @(posedge clk) begin
		if (done_word) begin
			list_q <= next_list;
			addr_q <= cur_addr + 32'd4;
			cnt_q <= cur_cnt + 5'd1;
		end
	end

endmodule

// File: src/mem_stage.sv
`timescale 1ns/10ps

module mem_stage import mem_stage_pkg::*; #(
	parameter int addr_w = 32
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              bubble,
	input  word_t             pc,
	input  word_t             insn,
	input  word_t             op0,
	input  word_t             op1,
	input  word_t             op2,
	output logic [addr_w-1:0] bus_addr,
	output logic              rd_req,
	output logic              wr_req,
	output byte_en_t          byte_en,
	output word_t             wr_data,
	input  word_t             rd_data,
	input  logic              bus_wait,
	output reg_num_t          st_read,
	input  word_t             st_data,
	output logic              wb_en,
	output reg_num_t          wb_num,
	output word_t             wb_data,
	output logic              stall,
	output logic              out_bubble,
	output word_t             out_pc,
	output word_t             out_insn
);

	logic s_rd_req, s_wr_req, s_busy, s_wb_req;
	logic [addr_w-1:0] s_addr;
	word_t s_wr_data, s_wb_data;
	byte_en_t s_byte_en;
	reg_num_t s_wb_num;

	logic b_rd_req, b_wr_req, b_busy, b_wb_req;
	logic [addr_w-1:0] b_addr;
	word_t b_wr_data, b_wb_data;
	reg_num_t b_wb_num;

	single_xfer #(.addr_w(addr_w)) u_single (
		.clk, .reset, .bubble, .insn, .op0, .op1, .op2, .rd_data, .bus_wait,
		.s_rd_req, .s_wr_req, .s_addr, .s_wr_data, .s_byte_en, .s_busy,
		.s_wb_req, .s_wb_num, .s_wb_data
	);

	block_xfer #(.addr_w(addr_w)) u_block (
		.clk, .reset, .bubble, .insn, .op0, .rd_data, .st_data, .bus_wait,
		.b_rd_req, .b_wr_req, .b_addr, .b_wr_data, .b_busy,
		.b_wb_req, .b_wb_num, .b_wb_data, .st_read
	);

	xfer_merge #(.addr_w(addr_w)) u_merge (
		.clk, .reset, .bubble, .pc, .insn,
		.s_rd_req, .s_wr_req, .s_addr, .s_wr_data, .s_byte_en, .s_busy,
		.s_wb_req, .s_wb_num, .s_wb_data,
		.b_rd_req, .b_wr_req, .b_addr, .b_wr_data, .b_busy,
		.b_wb_req, .b_wb_num, .b_wb_data,
		.bus_addr, .rd_req, .wr_req, .byte_en, .wr_data,
		.stall, .out_bubble, .out_pc, .out_insn, .wb_en, .wb_num, .wb_data
	);

endmodule

// File: src/mem_stage_pkg.sv
package mem_stage_pkg;

	// data and address word.
	typedef logic [31:0] word_t;

	// register index.
	typedef logic [3:0] reg_num_t;

	// register list of a block transfer.
	typedef logic [15:0] reg_list_t;

	// one write enable per byte lane.
	typedef logic [3:0] byte_en_t;

	// block transfer sequencer.
	typedef enum logic [1:0] {
		blk_idle,
		blk_xfer,
		blk_base_wb
	} block_state_t;

	// instruction flag bits.
	localparam int load_bit = 20;
	localparam int wb_bit = 21;
	localparam int byte_bit = 22;
	localparam int up_bit = 23;
	localparam int pre_bit = 24;

	// register fields.
	localparam int base_msb = 19;
	localparam int base_lsb = 16;
	localparam int rd_msb = 15;
	localparam int rd_lsb = 12;

	// ldr / str class.
	function automatic logic is_single_xfer(input word_t insn);
		return insn[27:26] == 2'b01;
	endfunction

	// ldm / stm class.
	function automatic logic is_block_xfer(input word_t insn);
		return insn[27:25] == 3'b100;
	endfunction

endpackage

// File: src/single_xfer.sv
`timescale 1ns/10ps

module single_xfer import mem_stage_pkg::*; #(
	parameter int addr_w = 32
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              bubble,
	input  word_t             insn,
	input  word_t             op0,
	input  word_t             op1,
	input  word_t             op2,
	input  word_t             rd_data,
	input  logic              bus_wait,
	output logic              s_rd_req,
	output logic              s_wr_req,
	output logic [addr_w-1:0] s_addr,
	output word_t             s_wr_data,
	output byte_en_t          s_byte_en,
	output logic              s_busy,
	output logic              s_wb_req,
	output reg_num_t          s_wb_num,
	output word_t             s_wb_data
);

	logic active;
	logic pend;
	logic req;
	logic complete;
	logic ld;
	logic wbf;
	logic byte_op;
	word_t off_addr;
	word_t xfer_addr;
	word_t rot_data;
	word_t load_val;
	logic [63:0] rd_pair;

	assign active = is_single_xfer(insn) && !bubble;
	assign ld = insn[load_bit];
	assign wbf = insn[wb_bit];
	assign byte_op = insn[byte_bit];

	assign off_addr = insn[up_bit] ? op0 + op1 : op0 - op1;
	// pre-index uses the offset address on the bus.
	assign xfer_addr = insn[pre_bit] ? off_addr : op0;

	// no new request while the base writeback is pending.
	assign req = active && !pend;
	assign complete = req && !bus_wait;

	assign s_rd_req = req && ld;
	assign s_wr_req = req && !ld;
	assign s_addr = req ? xfer_addr[addr_w-1:0] : '0;

	// rotate right by the byte offset.
	assign rd_pair = {rd_data, rd_data} >> {xfer_addr[1:0], 3'b000};
	assign rot_data = rd_pair[31:0];
	assign load_val = byte_op ? {24'd0, rot_data[7:0]} : rot_data;

	always_comb begin
		s_wr_data = '0;
		s_byte_en = '0;
		if (s_wr_req) begin
			if (byte_op) begin
				s_wr_data = {4{op2[7:0]}};
				s_byte_en = byte_en_t'(4'b0001 << xfer_addr[1:0]);
			end else begin
				s_wr_data = op2;
				s_byte_en = 4'b1111;
			end
		end
	end

	// load with writeback needs one more cycle for the base.
	assign s_busy = req && (bus_wait || (ld && wbf));

	always_comb begin
		s_wb_req = 1'b0;
		s_wb_num = '0;
		s_wb_data = '0;
		if (active && pend) begin
			s_wb_req = 1'b1;
			s_wb_num = insn[base_msb:base_lsb];
			s_wb_data = off_addr;
		end else if (complete && ld) begin
			s_wb_req = 1'b1;
			s_wb_num = insn[rd_msb:rd_lsb];
			s_wb_data = load_val;
		end else if (complete && wbf) begin
			// store writes the base right away.
			s_wb_req = 1'b1;
			s_wb_num = insn[base_msb:base_lsb];
			s_wb_data = off_addr;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pend <= 1'b0;
		end else begin
			pend <= complete && ld && wbf;
		end
	end

endmodule

// File: src/xfer_merge.sv
`timescale 1ns/10ps

module xfer_merge import mem_stage_pkg::*; #(
	parameter int addr_w = 32
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              bubble,
	input  word_t             pc,
	input  word_t             insn,
	input  logic              s_rd_req,
	input  logic              s_wr_req,
	input  logic [addr_w-1:0] s_addr,
	input  word_t             s_wr_data,
	input  byte_en_t          s_byte_en,
	input  logic              s_busy,
	input  logic              s_wb_req,
	input  reg_num_t          s_wb_num,
	input  word_t             s_wb_data,
	input  logic              b_rd_req,
	input  logic              b_wr_req,
	input  logic [addr_w-1:0] b_addr,
	input  word_t             b_wr_data,
	input  logic              b_busy,
	input  logic              b_wb_req,
	input  reg_num_t          b_wb_num,
	input  word_t             b_wb_data,
	output logic [addr_w-1:0] bus_addr,
	output logic              rd_req,
	output logic              wr_req,
	output byte_en_t          byte_en,
	output word_t             wr_data,
	output logic              stall,
	output logic              out_bubble,
	output word_t             out_pc,
	output word_t             out_insn,
	output logic              wb_en,
	output reg_num_t          wb_num,
	output word_t             wb_data
);

	logic [addr_w-1:0] any_addr;

	// idle unit drives zeros, so a plain or merges.
	assign any_addr = s_addr | b_addr;
	assign bus_addr = {any_addr[addr_w-1:2], 2'b00};
	assign rd_req = s_rd_req | b_rd_req;
	assign wr_req = s_wr_req | b_wr_req;
	assign wr_data = s_wr_data | b_wr_data;
	// block stores always write whole words.
	assign byte_en = s_byte_en | {4{b_wr_req}};

	// busy already drops in each unit's final cycle.
	assign stall = s_busy | b_busy;

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_en <= 1'b0;
			out_bubble <= 1'b1;
		end else begin
			wb_en <= s_wb_req | b_wb_req;
			out_bubble <= stall | bubble;
		end
	end

	always_ff @(posedge clk) begin
		wb_num <= s_wb_num | b_wb_num;
		wb_data <= s_wb_data | b_wb_data;
		out_pc <= pc;
		out_insn <= insn;
	end

endmodule

// File: tb/mem_stage_props.sv
`timescale 1ns/10ps

module mem_stage_props import mem_stage_pkg::*; #(
	parameter int addr_w = 32
) (
	input logic              clk,
	input logic              reset,
	input logic              rd_req,
	input logic              wr_req,
	input logic              bus_wait,
	input logic [addr_w-1:0] bus_addr,
	input word_t             wr_data,
	input byte_en_t          byte_en,
	input logic              wb_en,
	input logic              stall,
	input block_state_t      blk_state
);

	// failed assertions so far.
	int fail_total = 0;

	// one request type at a time.
	a_one_req: assert property (@(posedge clk) disable iff (reset) !(rd_req && wr_req))
		else begin
			$error("rd_req and wr_req high together");
			fail_total++;
		end

	// a waited request is held unchanged.
	a_hold: assert property (@(posedge clk) disable iff (reset)
		(rd_req || wr_req) && bus_wait |=> $stable(bus_addr) && $stable(wr_data)
			&& $stable(byte_en) && $stable(rd_req) && $stable(wr_req))
		else begin
			$error("bus request changed during a wait state");
			fail_total++;
		end

	a_wb_reset: assert property (@(posedge clk) reset |=> !wb_en)
		else begin
			$error("wb_en high after a reset cycle");
			fail_total++;
		end

	// sequencer is back home once stall drops.
	a_blk_idle: assert property (@(posedge clk) disable iff (reset)
		$fell(stall) |=> blk_state == blk_idle)
		else begin
			$error("block sequencer not idle after stall fell");
			fail_total++;
		end

endmodule

bind mem_stage mem_stage_props #(.addr_w(addr_w)) u_props (
	.clk, .reset, .rd_req, .wr_req, .bus_wait, .bus_addr, .wr_data, .byte_en,
	.wb_en, .stall, .blk_state(u_block.state)
);

// File: tb/tb_mem_stage.sv
`timescale 1ns/10ps

module tb_mem_stage import mem_stage_pkg::*;;

	// one instruction may move 17 words with up to 8 cycles each.
	localparam int n_insns = 238;
	localparam int limit_cycles = n_insns * 17 * 8;

	logic clk = 1'b0;
	logic reset;
	logic bubble;
	word_t pc;
	word_t insn;
	word_t op0;
	word_t op1;
	word_t op2;
	logic [31:0] bus_addr;
	logic rd_req;
	logic wr_req;
	byte_en_t byte_en;
	word_t wr_data;
	word_t rd_data;
	logic bus_wait;
	reg_num_t st_read;
	word_t st_data;
	logic wb_en;
	reg_num_t wb_num;
	word_t wb_data;
	logic stall;
	logic out_bubble;
	word_t out_pc;
	word_t out_insn;

	word_t mem [256];
	word_t shadow [256];
	word_t regs [16];
	reg_num_t exp_num [$];
	word_t exp_val [$];
	word_t exp_addr [$];

	integer seed = 32'h65b5;
	word_t wait_draw;
	int wait_run = 0;
	int errors = 0;
	int err_mark = 0;
	int assert_mark = 0;
	int pass_count = 0;
	int fail_count = 0;
	logic bubble_want = 1'b1;
	word_t last_pc;
	word_t last_insn;
	logic prev_valid = 1'b0;

	mem_stage u_dut (.*);

	always #4 clk = ~clk;

	// memory and register file models.
	assign rd_data = mem[bus_addr[9:2]];
	assign st_data = regs[st_read];

	always @(posedge clk) begin
		if (wr_req && !bus_wait) begin
			for (int k = 0; k < 4; k++) begin
				if (byte_en[k]) begin
					mem[bus_addr[9:2]][8*k +: 8] <= wr_data[8*k +: 8];
				end
			end
		end
	end

	// random wait states, never more than 7 in a row.
	always @(posedge clk) begin
		wait_draw = $random(seed);
		#1;
		if (reset || wait_run == 7) begin
			bus_wait = 1'b0;
		end else begin
			bus_wait = (wait_draw[1:0] == 2'b00);
		end
		wait_run = bus_wait ? wait_run + 1 : 0;
	end

	function automatic void note_mismatch(input string sig, input word_t want, input word_t got);
		$display("MISMATCH at %0t ns: %s expected %h, got %h", $time, sig, want, got);
		errors++;
	endfunction

	function automatic void note_error(input string msg);
		$display("ERROR at %0t ns: %s", $time, msg);
		errors++;
	endfunction

	function automatic void expect_wb(input reg_num_t num, input word_t val);
		exp_num.push_back(num);
		exp_val.push_back(val);
	endfunction

	function automatic word_t single_insn(input logic ld, input logic wbf, input logic bo,
			input logic up, input logic pre, input reg_num_t rn, input reg_num_t rd);
		word_t i;
		i = 32'he400_0000;
		i[load_bit] = ld;
		i[wb_bit] = wbf;
		i[byte_bit] = bo;
		i[up_bit] = up;
		i[pre_bit] = pre;
		i[base_msb:base_lsb] = rn;
		i[rd_msb:rd_lsb] = rd;
		return i;
	endfunction

	function automatic word_t block_insn(input logic ld, input logic wbf, input reg_num_t rn,
			input reg_list_t sel);
		word_t i;
		i = 32'he880_0000;
		i[load_bit] = ld;
		i[wb_bit] = wbf;
		i[base_msb:base_lsb] = rn;
		i[15:0] = sel;
		return i;
	endfunction

	// expected bus words, writebacks and memory for one instruction.
	function automatic void ref_mem_op(input word_t i, input word_t base, input word_t offs,
			input word_t sdata);
		word_t moved;
		word_t addr;
		word_t val;
		int n;
		moved = i[up_bit] ? base + offs : base - offs;
		if (i[27:26] == 2'b01) begin
			addr = i[pre_bit] ? moved : base;
			exp_addr.push_back({addr[31:2], 2'b00});
			if (i[load_bit]) begin
				val = shadow[addr[9:2]];
				for (int k = 0; k < addr[1:0]; k++) begin
					val = {val[7:0], val[31:8]};
				end
				if (i[byte_bit]) begin
					val = {24'd0, val[7:0]};
				end
				expect_wb(i[rd_msb:rd_lsb], val);
			end else if (i[byte_bit]) begin
				shadow[addr[9:2]][8*addr[1:0] +: 8] = sdata[7:0];
			end else begin
				shadow[addr[9:2]] = sdata;
			end
			if (i[wb_bit]) begin
				expect_wb(i[base_msb:base_lsb], moved);
			end
		end else if (i[27:25] == 3'b100) begin
			addr = base;
			n = 0;
			for (int r = 0; r < 16; r++) begin
				if (i[r]) begin
					exp_addr.push_back({addr[31:2], 2'b00});
					if (i[load_bit]) begin
						expect_wb(reg_num_t'(r), shadow[addr[9:2]]);
					end else begin
						shadow[addr[9:2]] = regs[r];
					end
					addr = addr + 32'd4;
					n++;
				end
			end
			if (i[wb_bit]) begin
				expect_wb(i[base_msb:base_lsb], base + 32'(4 * n));
			end
		end
	endfunction

	// hold the instruction until the stage accepts it.
	task automatic issue(input logic bub, input word_t i, input word_t a, input word_t b,
			input word_t c);
		bubble = bub;
		insn = i;
		op0 = a;
		op1 = b;
		op2 = c;
		pc = pc + 32'd4;
		if (!bub) begin
			ref_mem_op(i, a, b, c);
		end
		@(negedge clk);
		while (stall) begin
			@(posedge clk);
			#1;
			// a held instruction leaves a bubble behind.
			bubble_want = 1'b1;
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		bubble_want = bub;
	endtask

	task automatic finish_test(input string name);
		issue(1'b1, '0, '0, '0, '0);
		issue(1'b1, '0, '0, '0, '0);
		for (int i = 0; i < 256; i++) begin
			if (mem[i] !== shadow[i]) begin
				note_mismatch($sformatf("mem[%0d]", i), shadow[i], mem[i]);
			end
		end
		if (exp_num.size() != 0 || exp_addr.size() != 0) begin
			note_error("expected bus transfers or writebacks never happened");
		end
		if (u_dut.u_props.fail_total != assert_mark) begin
			note_error("a bus or writeback assertion failed during this test");
		end
		assert_mark = u_dut.u_props.fail_total;
		exp_num.delete();
		exp_val.delete();
		exp_addr.delete();
		if (errors == err_mark) begin
			pass_count++;
			$display("test %s: ok", name);
		end else begin
			fail_count++;
			$display("test %s: FAILED with %0d errors", name, errors - err_mark);
		end
		err_mark = errors;
	endtask

	always @(negedge clk) begin : compare
		word_t want;
		reg_num_t want_num;
		if (!reset) begin
			if ((rd_req || wr_req) && !bus_wait) begin
				if (exp_addr.size() == 0) begin
					note_error("bus transfer when none was expected");
				end else begin
					want = exp_addr.pop_front();
					if (bus_addr !== want) begin
						note_mismatch("bus_addr", want, bus_addr);
					end
				end
			end
			if (wb_en) begin
				if (exp_num.size() == 0) begin
					note_error("register writeback when none was expected");
				end else begin
					want_num = exp_num.pop_front();
					want = exp_val.pop_front();
					if (wb_num !== want_num) begin
						note_mismatch("wb_num", want_num, wb_num);
					end
					if (wb_data !== want) begin
						note_mismatch("wb_data", want, wb_data);
					end
				end
			end
			if (out_bubble !== bubble_want) begin
				note_mismatch("out_bubble", bubble_want, out_bubble);
			end
			if (prev_valid) begin
				if (out_pc !== last_pc) begin
					note_mismatch("out_pc", last_pc, out_pc);
				end
				if (out_insn !== last_insn) begin
					note_mismatch("out_insn", last_insn, out_insn);
				end
			end
		end
		last_pc = pc;
		last_insn = insn;
		prev_valid = !reset;
	end

	initial begin
		repeat (limit_cycles) @(posedge clk);
		$display("timeout: the run did not end within %0d clock cycles", limit_cycles);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		word_t r;
		word_t a;
		word_t b;
		word_t d;
		reg_list_t sel;
		reset = 1'b1;
		bubble = 1'b1;
		pc = '0;
		insn = '0;
		op0 = '0;
		op1 = '0;
		op2 = '0;
		bus_wait = 1'b0;
		for (int i = 0; i < 256; i++) begin
			mem[i] = 32'h9e37_79b9 * (i + 1);
			shadow[i] = mem[i];
		end
		for (int k = 0; k < 16; k++) begin
			regs[k] = 32'h0101_0101 * (k + 3);
		end
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;

		for (int bo = 0; bo < 2; bo++) begin
			for (int off = 0; off < 4; off++) begin
				issue(1'b0, single_insn(1'b1, 1'b0, bo[0], 1'b1, 1'b1, 4'd1, 4'd2),
					32'h100, off, '0);
			end
		end
		finish_test("loads");

		for (int bo = 0; bo < 2; bo++) begin
			for (int off = 0; off < 4; off++) begin
				issue(1'b0, single_insn(1'b0, 1'b0, bo[0], 1'b1, 1'b1, 4'd1, 4'd2),
					32'h200 + 32 * bo + 4 * off, off, 32'ha1b2_c3d4 + off);
			end
		end
		finish_test("stores");

		for (int k = 0; k < 16; k++) begin
			issue(1'b0, single_insn(k[0], k[1], 1'b0, k[2], k[3], 4'd3, 4'd4),
				32'h300, 8 + 4 * k, 32'h5a5a_0000 + k);
		end
		finish_test("indexing");

		issue(1'b0, block_insn(1'b1, 1'b1, 4'd5, 16'h0001), 32'h40, '0, '0);
		issue(1'b0, block_insn(1'b1, 1'b1, 4'd5, 16'h0a52), 32'h80, '0, '0);
		issue(1'b0, block_insn(1'b1, 1'b1, 4'd5, 16'hffff), 32'hc0, '0, '0);
		issue(1'b0, block_insn(1'b1, 1'b0, 4'd5, 16'h0a52), 32'h100, '0, '0);
		finish_test("load multiple");

		issue(1'b0, block_insn(1'b0, 1'b1, 4'd6, 16'h8421), 32'h380, '0, '0);
		issue(1'b0, block_insn(1'b0, 1'b0, 4'd6, 16'hffff), 32'h3c0, '0, '0);
		finish_test("store multiple");

		// mix of both classes with bubbles in between.
		for (int n = 0; n < 200; n++) begin
			r = $random(seed);
			a = $random(seed);
			b = $random(seed);
			d = $random(seed);
			sel = (r[31:16] == '0) ? 16'h0001 : r[31:16];
			if (r[3:0] == 4'd0) begin
				issue(1'b1, r, a, b, d);
			end else if (r[4]) begin
				issue(1'b0, single_insn(r[5], r[6], r[7], r[8], r[9], r[19:16], r[15:12]),
					{22'd0, a[9:0]}, {24'd0, b[7:0]}, d);
			end else begin
				issue(1'b0, block_insn(r[5], r[6], r[11:8], sel),
					{22'd0, a[9:2], 2'b00}, '0, '0);
			end
		end
		finish_test("random mix");

		$display("%0d tests passed, %0d tests failed", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule
